//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_slave_translator
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Finished with errors

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
hdl/xlat_pkg.sv
hdl/wait_state_sequencer.sv
hdl/request_path.sv
hdl/read_return.sv
hdl/slave_translator.sv
bench/fixed_timing_slave.sv
bench/tb_slave_translator.sv

//--- bench/fixed_timing_slave.sv
`timescale 1ns/10ps
`default_nettype none

module fixed_timing_slave #(
   parameter int              READ_LATENCY = 2,
   parameter xlat_pkg::data_t SEED_XOR     = 32'ha5c3_0f00
) (
   input  wire                   clk,
   input  wire                   reset,
   input  xlat_pkg::word_addr_t  av_address,
   input  wire                   av_read,
   input  wire                   av_write,
   input  wire                   av_chipselect,
   input  xlat_pkg::data_t       av_writedata,
   input  xlat_pkg::byte_en_t    av_writebyteenable,
   output xlat_pkg::data_t       av_readdata
);

   // 64 words, indexed by the low word address bits
   xlat_pkg::data_t mem [64];
   logic [5:0]      addr_pipe [READ_LATENCY];

   initial begin
      for (int w = 0; w < 64; w++) begin
         mem[w] = xlat_pkg::data_t'(w) ^ SEED_XOR;
      end
   end

   // Byte writes
   always @(posedge clk) begin
      if (av_chipselect && av_write) begin
         for (int b = 0; b < 4; b++) begin
            if (av_writebyteenable[b]) begin
               mem[av_address[5:0]][8*b +: 8] <= av_writedata[8*b +: 8];
            end
         end
      end
   end

   // ----------------------------------------------------------
   // Read latency pipe, one address per av_read cycle
   // ----------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < READ_LATENCY; i++) begin
            addr_pipe[i] <= '0;
         end
      end else begin
         if (av_read) begin
            addr_pipe[0] <= av_address[5:0];
         end
         for (int i = 1; i < READ_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
         end
      end
   end

   assign av_readdata = mem[addr_pipe[READ_LATENCY-1]];

endmodule

`default_nettype wire

//--- bench/tb_slave_translator.sv
`timescale 1ns/10ps
`default_nettype none

module tb_slave_translator;

   localparam int              SETUP_CYCLES      = 1;
   localparam int              READ_WAIT_CYCLES  = 2;
   localparam int              WRITE_WAIT_CYCLES = 1;
   localparam int              HOLD_CYCLES       = 1;
   localparam int              READ_LATENCY      = 2;
   localparam xlat_pkg::data_t SEED_XOR          = 32'ha5c3_0f00;
   localparam logic [31:0]     LCG_SEED          = 32'h18c6b9aa;
   localparam int              MAX_REQ_CYCLES    = 16;
   // 48 transfers at 8 cycles worst case, plus margin
   localparam int              MAX_CYCLES        = 48 * 8 + 100;
   localparam int              RD_ACCEPT = SETUP_CYCLES + READ_WAIT_CYCLES;
   localparam int              WR_ACCEPT = SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES;

   logic                 clk;
   logic                 reset;
   xlat_pkg::host_addr_t uav_address;
   logic                 uav_read;
   logic                 uav_write;
   xlat_pkg::data_t      uav_writedata;
   xlat_pkg::byte_en_t   uav_byteenable;
   logic                 uav_waitrequest;
   xlat_pkg::data_t      uav_readdata;
   logic                 uav_readdatavalid;
   xlat_pkg::word_addr_t av_address;
   logic                 av_read;
   logic                 av_write;
   xlat_pkg::data_t      av_writedata;
   xlat_pkg::byte_en_t   av_byteenable;
   xlat_pkg::byte_en_t   av_writebyteenable;
   logic                 av_begintransfer;
   logic                 av_chipselect;
   xlat_pkg::data_t      av_readdata;

   // Reference model and bookkeeping
   xlat_pkg::data_t ref_mem [64];
   xlat_pkg::data_t exp_rd [64];
   logic [5:0]      rd_issued;
   logic [5:0]      rd_returned;
   logic [31:0]     rng_state;
   int              req_cycle;
   int              mismatch_count;
   int              other_count;
   int              cycle_count;
   logic            accept_seen;
   logic            rdv_seen;

   slave_translator #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES),
      .READ_LATENCY      (READ_LATENCY)
   ) dut_i (
      .clk (clk), .reset (reset),
      .uav_address (uav_address), .uav_read (uav_read), .uav_write (uav_write),
      .uav_writedata (uav_writedata), .uav_byteenable (uav_byteenable),
      .uav_waitrequest (uav_waitrequest), .uav_readdata (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .av_address (av_address), .av_read (av_read), .av_write (av_write),
      .av_writedata (av_writedata), .av_byteenable (av_byteenable),
      .av_writebyteenable (av_writebyteenable), .av_begintransfer (av_begintransfer),
      .av_chipselect (av_chipselect), .av_readdata (av_readdata)
   );

   fixed_timing_slave #(
      .READ_LATENCY (READ_LATENCY),
      .SEED_XOR     (SEED_XOR)
   ) slave_i (
      .clk (clk), .reset (reset),
      .av_address (av_address), .av_read (av_read), .av_write (av_write),
      .av_chipselect (av_chipselect), .av_writedata (av_writedata),
      .av_writebyteenable (av_writebyteenable), .av_readdata (av_readdata)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ----------------------------------------------------------
   // Expected bus behavior from the request's cycle index
   // ----------------------------------------------------------
   logic                 in_req;
   logic                 exp_read_accept;
   logic                 exp_write_accept;
   logic                 exp_waitrequest;
   logic                 exp_av_read;
   logic                 exp_av_write;
   logic                 exp_begintransfer;
   logic                 exp_chipselect;
   xlat_pkg::byte_en_t   exp_wbe;
   xlat_pkg::word_addr_t exp_word_addr;
   xlat_pkg::data_t      exp_rdata;
   logic [5:0]           outstanding;
   logic [5:0]           reset_outputs;

   assign in_req            = uav_read | uav_write;
   assign exp_read_accept   = uav_read && (req_cycle == RD_ACCEPT);
   assign exp_write_accept  = uav_write && (req_cycle == WR_ACCEPT);
   assign exp_waitrequest   = !(exp_read_accept || exp_write_accept);
   assign exp_av_read       = uav_read && (req_cycle >= SETUP_CYCLES);
   assign exp_av_write      = uav_write && (req_cycle >= SETUP_CYCLES) &&
                              (req_cycle <= SETUP_CYCLES + WRITE_WAIT_CYCLES);
   assign exp_begintransfer = in_req && (req_cycle == 0);
   // Byte lanes only during the write strobe, none during a read strobe
   assign exp_wbe           = exp_av_write ? uav_byteenable : 4'h0;
   assign exp_word_addr     = xlat_pkg::word_addr_t'(uav_address >> 2);
   assign exp_rdata         = exp_rd[rd_returned];
   // Reads accepted and not yet returned, the returning one excluded
   assign outstanding       = rd_issued - rd_returned - {5'b0, uav_readdatavalid};
   assign exp_chipselect    = in_req || (outstanding != 6'd0);
   assign reset_outputs     = {uav_waitrequest, uav_readdatavalid, av_read,
                               av_write, av_begintransfer, av_chipselect};

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         accept_seen <= 1'b0;
         rdv_seen    <= 1'b0;
      end else begin
         accept_seen <= in_req & ~uav_waitrequest;
         rdv_seen    <= uav_readdatavalid;
      end
   end

   always @(negedge clk or posedge reset) begin
      if (reset) begin
         rd_returned <= '0;
      end else if (rdv_seen) begin
         rd_returned <= rd_returned + 6'd1;
      end
   end

   task automatic flag_bit_mismatch(input string name, input logic got, input logic expected);
      mismatch_count++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, expected);
   endtask

   task automatic flag_word_mismatch(input string name, input logic [31:0] got,
                                     input logic [31:0] expected);
      mismatch_count++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
   endtask

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------
   check_reset_state: assert property (@(posedge clk)
      ($past(reset) && !reset) |-> reset_outputs == 6'b100000)
      else flag_word_mismatch(
                         "{waitrequest,readdatavalid,read,write,begintransfer,chipselect}",
                         32'($sampled(reset_outputs)), 32'h20);

   check_waitrequest: assert property (@(posedge clk) disable iff (reset)
      in_req |-> uav_waitrequest == exp_waitrequest)
      else flag_bit_mismatch("uav_waitrequest", $sampled(uav_waitrequest),
                             $sampled(exp_waitrequest));

   check_av_read: assert property (@(posedge clk) disable iff (reset) av_read == exp_av_read)
      else flag_bit_mismatch("av_read", $sampled(av_read), $sampled(exp_av_read));

   check_av_write: assert property (@(posedge clk) disable iff (reset) av_write == exp_av_write)
      else flag_bit_mismatch("av_write", $sampled(av_write), $sampled(exp_av_write));

   check_address: assert property (@(posedge clk) disable iff (reset)
      (av_read || av_write) |-> av_address == exp_word_addr)
      else flag_word_mismatch("av_address", 32'($sampled(av_address)),
                              32'($sampled(exp_word_addr)));

   check_byteenable: assert property (@(posedge clk) disable iff (reset)
      (av_read || av_write) |-> av_byteenable == uav_byteenable)
      else flag_word_mismatch("av_byteenable", 32'($sampled(av_byteenable)),
                              32'($sampled(uav_byteenable)));

   check_writedata: assert property (@(posedge clk) disable iff (reset)
      av_write |-> av_writedata == uav_writedata)
      else flag_word_mismatch("av_writedata", $sampled(av_writedata), $sampled(uav_writedata));

   check_writebyteenable: assert property (@(posedge clk) disable iff (reset)
      (av_read || av_write) |-> av_writebyteenable == exp_wbe)
      else flag_word_mismatch("av_writebyteenable", 32'($sampled(av_writebyteenable)),
                              32'($sampled(exp_wbe)));

   check_begintransfer: assert property (@(posedge clk) disable iff (reset)
      av_begintransfer == exp_begintransfer)
      else flag_bit_mismatch("av_begintransfer", $sampled(av_begintransfer),
                             $sampled(exp_begintransfer));

   // A one-bit mismatch always expects the opposite value
   check_readdatavalid: assert property (@(posedge clk) disable iff (reset)
      uav_readdatavalid == $past(exp_read_accept, READ_LATENCY))
      else flag_bit_mismatch("uav_readdatavalid", $sampled(uav_readdatavalid),
                             !$sampled(uav_readdatavalid));

   check_readdata: assert property (@(posedge clk) disable iff (reset)
      uav_readdatavalid |-> uav_readdata == exp_rdata)
      else flag_word_mismatch("uav_readdata", $sampled(uav_readdata), $sampled(exp_rdata));

   check_chipselect: assert property (@(posedge clk) disable iff (reset)
      av_chipselect == exp_chipselect)
      else flag_bit_mismatch("av_chipselect", $sampled(av_chipselect), $sampled(exp_chipselect));

   // ----------------------------------------------------------
   // Stimulus helpers
   // ----------------------------------------------------------
   function automatic logic [31:0] next_random();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic xlat_pkg::data_t merge_bytes(input xlat_pkg::data_t old_word,
                                                   input xlat_pkg::data_t new_word,
                                                   input xlat_pkg::byte_en_t be);
      xlat_pkg::data_t result;
      result = old_word;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            result[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return result;
   endfunction

   // Called on a falling edge, returns on the falling edge after accept
   task automatic drive_transfer(input logic is_write, input xlat_pkg::host_addr_t addr,
                                 input xlat_pkg::data_t wdata, input xlat_pkg::byte_en_t be);
      logic [5:0] idx;
      idx            = addr[7:2];
      uav_address    = addr;
      uav_writedata  = wdata;
      uav_byteenable = be;
      uav_read       = ~is_write;
      uav_write      = is_write;
      req_cycle      = 0;
      @(negedge clk);
      while (!accept_seen && req_cycle < MAX_REQ_CYCLES) begin
         req_cycle++;
         @(negedge clk);
      end
      if (!accept_seen) begin
         other_count++;
         $display("Request to address %h was not accepted within %0d cycles",
                  addr, MAX_REQ_CYCLES);
      end else if (is_write) begin
         ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
      end else begin
         exp_rd[rd_issued] = ref_mem[idx];
         rd_issued         = rd_issued + 6'd1;
      end
   endtask

   task automatic go_idle();
      uav_read  = 1'b0;
      uav_write = 1'b0;
      @(negedge clk);
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > MAX_CYCLES) begin
         $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
         $display("Done: %0d mismatches, %0d other errors", mismatch_count, other_count + 1);
         $display("Finished with errors");
         $finish;
      end
   end

   // ----------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------
   initial begin
      logic [31:0] r;
      int          n;
      reset          = 1'b1;
      uav_address    = '0;
      uav_read       = 1'b0;
      uav_write      = 1'b0;
      uav_writedata  = '0;
      uav_byteenable = '0;
      rng_state      = LCG_SEED;
      rd_issued      = '0;
      req_cycle      = 0;
      mismatch_count = 0;
      other_count    = 0;
      cycle_count    = 0;
      for (n = 0; n < 64; n++) begin
         ref_mem[n] = xlat_pkg::data_t'(n) ^ SEED_XOR;
      end
      repeat (2) @(negedge clk);
      reset = 1'b0;
      go_idle();
      go_idle();

      // Random mix over 16 words so reads hit earlier writes
      for (n = 0; n < 40; n++) begin
         r = next_random();
         drive_transfer(r[24], {26'h0, r[31:26]}, next_random(), r[23:20]);
         if (r[19]) begin
            go_idle();
         end
      end

      // Back-to-back reads keep several in flight
      for (n = 0; n < 8; n++) begin
         r = next_random();
         drive_transfer(1'b0, {26'h0, r[31:26]}, '0, 4'hf);
      end
      go_idle();
      while (rd_returned != rd_issued) begin
         @(negedge clk);
      end
      go_idle();

      $display("Done: %0d mismatches, %0d other errors", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/read_return.sv
`timescale 1ns/10ps
`default_nettype none

module read_return #(
   parameter int READ_LATENCY = 2
) (
   input  wire                clk,
   input  wire                reset,
   input  wire                read_accept,
   input  wire                uav_read,
   input  wire                uav_write,
   input  xlat_pkg::data_t    av_readdata,
   output logic               uav_readdatavalid,
   output xlat_pkg::data_t    uav_readdata,
   output logic               av_chipselect
);

   // Every stage but the last, i.e. reads still waiting on data
   localparam logic [READ_LATENCY-1:0] PEND_MASK = {READ_LATENCY{1'b1}} >> 1;

   // One bit per accepted read, oldest at the top
   logic [READ_LATENCY-1:0] accept_pipe;
   logic                    read_pending;

   // ----------------------------------------------------------
   // Latency shift register
   // ----------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         accept_pipe <= '0;
      end else begin
         accept_pipe[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            accept_pipe[i] <= accept_pipe[i-1];
         end
      end
   end

   // Data comes straight from the slave, qualified by the last stage
   assign uav_readdatavalid = accept_pipe[READ_LATENCY-1];
   assign uav_readdata      = av_readdata;

   // ----------------------------------------------------------
   // Chipselect
   // ----------------------------------------------------------

   // Keep the slave selected until the last pending read returns
   assign read_pending  = |(accept_pipe & PEND_MASK);
   assign av_chipselect = uav_read | uav_write | read_pending;

endmodule

`default_nettype wire

//--- hdl/request_path.sv
`timescale 1ns/10ps
`default_nettype none

module request_path (
   input  wire                      clk,
   input  wire                      reset,
   input  xlat_pkg::host_addr_t     uav_address,
   input  wire                      uav_read,
   input  wire                      uav_write,
   input  xlat_pkg::data_t          uav_writedata,
   input  xlat_pkg::byte_en_t       uav_byteenable,
   input  wire                      uav_waitrequest,
   output xlat_pkg::word_addr_t     av_address,
   output xlat_pkg::data_t          av_writedata,
   output xlat_pkg::byte_en_t       av_byteenable,
   output xlat_pkg::byte_en_t       av_writebyteenable,
   output logic                     av_begintransfer
);

   // Set once the first cycle of a stalled request has gone by
   logic end_begintransfer;

   // ----------------------------------------------------------
   // Address and data
   // ----------------------------------------------------------

   // Byte address to word address, offset bits dropped
   assign av_address   = uav_address[31:2];
   assign av_writedata = uav_writedata;

   assign av_byteenable      = uav_byteenable;
   assign av_writebyteenable = {4{uav_write}} & uav_byteenable;

   // ----------------------------------------------------------
   // Begintransfer
   // ----------------------------------------------------------
   assign av_begintransfer = (uav_read | uav_write) & ~end_begintransfer;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         end_begintransfer <= 1'b0;
      end else if (!uav_waitrequest) begin
         // Accept edge, next request starts fresh
         end_begintransfer <= 1'b0;
      end else if (av_begintransfer) begin
         end_begintransfer <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hdl/slave_translator.sv
`timescale 1ns/10ps
`default_nettype none

module slave_translator #(
   parameter int SETUP_CYCLES      = 1,
   parameter int READ_WAIT_CYCLES  = 2,
   parameter int WRITE_WAIT_CYCLES = 1,
   parameter int HOLD_CYCLES       = 1,
   parameter int READ_LATENCY      = 2
) (
   input  wire                      clk,
   input  wire                      reset,

   // Host port
   input  xlat_pkg::host_addr_t     uav_address,
   input  wire                      uav_read,
   input  wire                      uav_write,
   input  xlat_pkg::data_t          uav_writedata,
   input  xlat_pkg::byte_en_t       uav_byteenable,
   output logic                     uav_waitrequest,
   output xlat_pkg::data_t          uav_readdata,
   output logic                     uav_readdatavalid,

   // Fixed-timing slave port
   output xlat_pkg::word_addr_t     av_address,
   output logic                     av_read,
   output logic                     av_write,
   output xlat_pkg::data_t          av_writedata,
   output xlat_pkg::byte_en_t       av_byteenable,
   output xlat_pkg::byte_en_t       av_writebyteenable,
   output logic                     av_begintransfer,
   output logic                     av_chipselect,
   input  xlat_pkg::data_t          av_readdata
);

   // Read accepted on this edge
   logic read_accept;

   // ----------------------------------------------------------
   // Control
   // ----------------------------------------------------------
   wait_state_sequencer #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES)
   ) sequencer_i (
      .clk             (clk),
      .reset           (reset),
      .uav_read        (uav_read),
      .uav_write       (uav_write),
      .uav_waitrequest (uav_waitrequest),
      .av_read         (av_read),
      .av_write        (av_write),
      .read_accept     (read_accept)
   );

   // ----------------------------------------------------------
   // Datapaths
   // ----------------------------------------------------------
   request_path request_i (
      .clk                (clk),
      .reset              (reset),
      .uav_address        (uav_address),
      .uav_read           (uav_read),
      .uav_write          (uav_write),
      .uav_writedata      (uav_writedata),
      .uav_byteenable     (uav_byteenable),
      .uav_waitrequest    (uav_waitrequest),
      .av_address         (av_address),
      .av_writedata       (av_writedata),
      .av_byteenable      (av_byteenable),
      .av_writebyteenable (av_writebyteenable),
      .av_begintransfer   (av_begintransfer)
   );

   read_return #(
      .READ_LATENCY (READ_LATENCY)
   ) return_i (
      .clk               (clk),
      .reset             (reset),
      .read_accept       (read_accept),
      .uav_read          (uav_read),
      .uav_write         (uav_write),
      .av_readdata       (av_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_readdata      (uav_readdata),
      .av_chipselect     (av_chipselect)
   );

endmodule

`default_nettype wire

//--- hdl/wait_state_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module wait_state_sequencer #(
   parameter int SETUP_CYCLES      = 1,
   parameter int READ_WAIT_CYCLES  = 2,
   parameter int WRITE_WAIT_CYCLES = 1,
   parameter int HOLD_CYCLES       = 1
) (
   input  wire  clk,
   input  wire  reset,
   input  wire  uav_read,
   input  wire  uav_write,
   output logic uav_waitrequest,
   output logic av_read,
   output logic av_write,
   output logic read_accept
);

   // Counter values at the phase boundaries
   localparam int RD_END  = SETUP_CYCLES + READ_WAIT_CYCLES;
   localparam int WR_END  = SETUP_CYCLES + WRITE_WAIT_CYCLES;
   localparam int WR_DONE = WR_END + HOLD_CYCLES;

   xlat_pkg::wait_cnt_t  wait_cnt;
   xlat_pkg::wait_cnt_t  access_end;
   xlat_pkg::wait_cnt_t  done_cnt;
   xlat_pkg::seq_state_t phase;
   logic                 reset_override;
   logic                 request;

   assign request = uav_read | uav_write;

   // Writes keep their data for the hold cycles, reads end with the access
   assign access_end = uav_write ? xlat_pkg::wait_cnt_t'(WR_END)  : xlat_pkg::wait_cnt_t'(RD_END);
   assign done_cnt   = uav_write ? xlat_pkg::wait_cnt_t'(WR_DONE) : xlat_pkg::wait_cnt_t'(RD_END);

   // ----------------------------------------------------------
   // Phase decode from the counter
   // ----------------------------------------------------------
   always_comb begin
      if (!request || reset_override) begin
         phase = xlat_pkg::seq_idle;
      end else if (wait_cnt < xlat_pkg::wait_cnt_t'(SETUP_CYCLES)) begin
         phase = xlat_pkg::seq_setup;
      end else if (wait_cnt == done_cnt) begin
         phase = xlat_pkg::seq_done;
      end else if (wait_cnt <= access_end) begin
         phase = xlat_pkg::seq_access;
      end else begin
         phase = xlat_pkg::seq_hold;
      end
   end

   // Strobes only inside the access window
   // (a zero-hold write finishes inside it)
   assign av_read  = uav_read &&
                     (phase == xlat_pkg::seq_access || phase == xlat_pkg::seq_done);
   assign av_write = uav_write &&
                     (phase == xlat_pkg::seq_access ||
                      (phase == xlat_pkg::seq_done && wait_cnt <= access_end));

   // Override keeps phase idle, so the host is held after reset
   assign uav_waitrequest = (phase != xlat_pkg::seq_done);
   assign read_accept     = uav_read & ~uav_waitrequest;

   // ----------------------------------------------------------
   // Wait-state counter
   // ----------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt       <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         // Restart at accept or when the bus goes idle
         if (phase == xlat_pkg::seq_done || phase == xlat_pkg::seq_idle) begin
            wait_cnt <= '0;
         end else begin
            wait_cnt <= wait_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/xlat_pkg.sv
`default_nettype none

package xlat_pkg;

   // ----------------------------------------------------------
   // Bus widths
   // ----------------------------------------------------------

   // Host side addresses bytes
   typedef logic [31:0] host_addr_t;

   // Slave side addresses 32-bit words
   typedef logic [29:0] word_addr_t;

   typedef logic [31:0] data_t;
   typedef logic [3:0]  byte_en_t;

   // Enough for setup + wait + hold up to 15 cycles
   typedef logic [3:0]  wait_cnt_t;

   // ----------------------------------------------------------
   // Wait-state sequencer phases
   // ----------------------------------------------------------
   typedef enum logic [2:0] {
      seq_idle,
      seq_setup,
      seq_access,
      seq_hold,
      seq_done
   } seq_state_t;

endpackage

`default_nettype wire
